// File: include/dma_defs.svh
// DMA job path parameters: widths, queue depths and dimension count
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Datapath widths
`define DMA_ADDR_W 32
`define DMA_LEN_W 16
`define DMA_REP_W 8
`define DMA_ID_W 8

// A page is 4 KiB
`define DMA_PAGE_BITS 12

// Outer dimensions, one repetition stage each
`define DMA_NUM_REP 2

// Job FIFO entries
`define DMA_JOB_DEPTH 4

// Outstanding bursts whose last flag is remembered
`define DMA_RSP_DEPTH 8

`endif

// File: logic/dma_pkg.sv
// DMA job path types: address and length vectors, job, ND item and burst structs
`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_LEN_W-1:0]  len_t;
  typedef logic [`DMA_REP_W-1:0]  rep_t;
  typedef logic [`DMA_ID_W-1:0]   tid_t;

  // One-dimensional transfer as seen by the backend
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
    logic  last;
  } burst_t;

  // Two-dimensional job, one count and stride pair per outer dimension
  typedef struct packed {
    addr_t                        src;
    addr_t                        dst;
    len_t                         len;
    rep_t  [`DMA_NUM_REP-1:0]     reps;
    addr_t [`DMA_NUM_REP-1:0]     src_stride;
    addr_t [`DMA_NUM_REP-1:0]     dst_stride;
  } job_t;

  // Job in flight through the stages; last marks the end of its transfer
  typedef struct packed {
    job_t job;
    logic last;
  } nd_item_t;

endpackage

`default_nettype wire

// File: logic/dma_job_queue.sv
// Job FIFO that buffers incoming jobs and hands them on as ND items marked last
`default_nettype none

module dma_job_queue #(
  parameter int unsigned DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  dma_pkg::job_t    job_i,
  input  logic             job_valid_i,
  output logic             job_ready_o,
  output dma_pkg::nd_item_t item_o,
  output logic             item_valid_o,
  input  logic             item_ready_i
);

  import dma_pkg::*;

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  job_t            mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign job_ready_o  = (count_q != CntW'(DEPTH));
  assign item_valid_o = (count_q != '0);
  assign push = job_valid_i & job_ready_o;
  assign pop  = item_valid_o & item_ready_i;

  // Every job is a complete transfer on its own
  assign item_o = '{job: mem_q[rd_ptr_q], last: 1'b1};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage only
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= job_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/dma_rep_stage.sv
// Repetition stage that replays one ND item along a single outer dimension
`default_nettype none

module dma_rep_stage #(
  parameter int unsigned DIM = 0
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::nd_item_t item_i,
  input  logic              item_valid_i,
  output logic              item_ready_o,
  output dma_pkg::nd_item_t item_o,
  output logic              item_valid_o,
  input  logic              item_ready_i
);

  import dma_pkg::*;

  nd_item_t item_q;
  logic     valid_q;
  rep_t     cnt_q;
  addr_t    src_q;
  addr_t    dst_q;

  rep_t     total;
  logic     final_copy;
  logic     in_fire;
  logic     out_fire;

  // A count of zero still means one pass
  assign total = (item_q.job.reps[DIM] == '0) ? rep_t'(1) : item_q.job.reps[DIM];
  assign final_copy = (cnt_q == total - rep_t'(1));

  assign item_valid_o = valid_q;
  assign out_fire     = valid_q & item_ready_i;

  // Accept the next item in the cycle the final copy leaves
  assign item_ready_o = ~valid_q | (item_ready_i & final_copy);
  assign in_fire      = item_valid_i & item_ready_o;

  always_comb begin
    item_o              = item_q;
    item_o.job.src      = src_q;
    item_o.job.dst      = dst_q;
    item_o.job.reps[DIM] = '0;
    item_o.last         = item_q.last & final_copy;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      if (in_fire) begin
        valid_q <= 1'b1;
        cnt_q   <= '0;
      end else if (out_fire) begin
        if (final_copy) begin
          valid_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // Held item and running addresses
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      item_q <= item_i;
      src_q  <= item_i.job.src;
      dst_q  <= item_i.job.dst;
    end else if (out_fire && !final_copy) begin
      src_q <= src_q + item_q.job.src_stride[DIM];
      dst_q <= dst_q + item_q.job.dst_stride[DIM];
    end
  end

endmodule

`default_nettype wire

// File: logic/dma_page_splitter.sv
// Page splitter that cuts bursts at source and destination 4 KiB page boundaries
`default_nettype none

`include "dma_defs.svh"

module dma_page_splitter (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::nd_item_t item_i,
  input  logic              item_valid_i,
  output logic              item_ready_o,
  output dma_pkg::burst_t   burst_o,
  output logic              burst_valid_o,
  input  logic              burst_ready_i
);

  import dma_pkg::*;

  localparam len_t PageSize = len_t'(1) << `DMA_PAGE_BITS;

  logic  valid_q;
  addr_t src_q;
  addr_t dst_q;
  len_t  rem_q;
  logic  last_q;

  len_t  src_room;
  len_t  dst_room;
  len_t  piece;
  logic  final_piece;
  logic  in_fire;
  logic  out_fire;

  // Bytes left up to the next page boundary
  assign src_room = PageSize -
                    {{(`DMA_LEN_W - `DMA_PAGE_BITS){1'b0}}, src_q[`DMA_PAGE_BITS-1:0]};
  assign dst_room = PageSize -
                    {{(`DMA_LEN_W - `DMA_PAGE_BITS){1'b0}}, dst_q[`DMA_PAGE_BITS-1:0]};

  always_comb begin
    piece = rem_q;
    if (src_room < piece) begin
      piece = src_room;
    end
    if (dst_room < piece) begin
      piece = dst_room;
    end
  end

  assign final_piece = (piece == rem_q);

  assign burst_o       = '{src: src_q, dst: dst_q, len: piece, last: last_q & final_piece};
  assign burst_valid_o = valid_q;
  assign out_fire      = valid_q & burst_ready_i;
  assign item_ready_o  = ~valid_q | (burst_ready_i & final_piece);
  assign in_fire       = item_valid_i & item_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_fire) begin
      valid_q <= 1'b1;
    end else if (out_fire && final_piece) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      src_q  <= item_i.job.src;
      dst_q  <= item_i.job.dst;
      rem_q  <= item_i.job.len;
      last_q <= item_i.last;
    end else if (out_fire && !final_piece) begin
      // Advance both ranges past the piece just sent
      src_q <= src_q + {{(`DMA_ADDR_W - `DMA_LEN_W){1'b0}}, piece};
      dst_q <= dst_q + {{(`DMA_ADDR_W - `DMA_LEN_W){1'b0}}, piece};
      rem_q <= rem_q - piece;
    end
  end

endmodule

`default_nettype wire

// File: logic/dma_id_tracker.sv
// Transfer ID tracker that issues IDs and retires jobs on last-burst responses
`default_nettype none

`include "dma_defs.svh"

module dma_id_tracker (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          issue_i,
  input  logic          burst_last_i,
  input  logic          burst_fire_i,
  output logic          flags_full_o,
  input  logic          rsp_valid_i,
  output logic          rsp_ready_o,
  output dma_pkg::tid_t next_id_o,
  output dma_pkg::tid_t done_id_o,
  output logic          busy_o
);

  import dma_pkg::*;

  localparam int unsigned Depth = `DMA_RSP_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  logic [Depth-1:0] flags_q;
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;
  tid_t             next_q;
  tid_t             done_q;
  logic             pop;

  assign flags_full_o = (count_q == CntW'(Depth));
  assign rsp_ready_o  = (count_q != '0);
  assign pop          = rsp_valid_i & rsp_ready_o;

  assign next_id_o = next_q;
  assign done_id_o = done_q;
  assign busy_o    = (next_q != done_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      next_q   <= '0;
      done_q   <= '0;
    end else begin
      if (issue_i) begin
        next_q <= next_q + 1'b1;
      end
      // Job retires with the response to its final burst
      if (pop && flags_q[rd_ptr_q]) begin
        done_q <= done_q + 1'b1;
      end
      if (burst_fire_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (burst_fire_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !burst_fire_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (burst_fire_i) begin
      flags_q[wr_ptr_q] <= burst_last_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/dma_wrap.sv
// DMA job path top: job FIFO, repetition stage chain, page splitter and ID tracker
`default_nettype none

`include "dma_defs.svh"

module dma_wrap (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  dma_pkg::job_t   job_i,
  input  logic            job_valid_i,
  output logic            job_ready_o,
  output dma_pkg::burst_t burst_o,
  output logic            burst_valid_o,
  input  logic            burst_ready_i,
  input  logic            rsp_valid_i,
  output logic            rsp_ready_o,
  output dma_pkg::tid_t   next_id_o,
  output dma_pkg::tid_t   done_id_o,
  output logic            busy_o
);

  import dma_pkg::*;

  // Index k feeds stage k, the last index feeds the splitter
  nd_item_t [`DMA_NUM_REP:0] stage_item;
  logic     [`DMA_NUM_REP:0] stage_valid;
  logic     [`DMA_NUM_REP:0] stage_ready;

  logic split_valid;
  logic split_ready;
  logic flags_full;
  logic issue;
  logic burst_fire;

  assign issue = job_valid_i & job_ready_o;

  // Hold bursts back while the tracker cannot record another flag
  assign burst_valid_o = split_valid & ~flags_full;
  assign split_ready   = burst_ready_i & ~flags_full;
  assign burst_fire    = burst_valid_o & burst_ready_i;

  dma_job_queue #(
    .DEPTH ( `DMA_JOB_DEPTH )
  ) i_job_queue (
    .clk_i,
    .arst_n_i,
    .job_i,
    .job_valid_i,
    .job_ready_o,
    .item_o       ( stage_item[0]  ),
    .item_valid_o ( stage_valid[0] ),
    .item_ready_i ( stage_ready[0] )
  );

  for (genvar k = 0; k < `DMA_NUM_REP; k++) begin : gen_rep
    dma_rep_stage #(
      .DIM ( k )
    ) i_rep_stage (
      .clk_i,
      .arst_n_i,
      .item_i       ( stage_item[k]    ),
      .item_valid_i ( stage_valid[k]   ),
      .item_ready_o ( stage_ready[k]   ),
      .item_o       ( stage_item[k+1]  ),
      .item_valid_o ( stage_valid[k+1] ),
      .item_ready_i ( stage_ready[k+1] )
    );
  end

  dma_page_splitter i_page_splitter (
    .clk_i,
    .arst_n_i,
    .item_i        ( stage_item[`DMA_NUM_REP]  ),
    .item_valid_i  ( stage_valid[`DMA_NUM_REP] ),
    .item_ready_o  ( stage_ready[`DMA_NUM_REP] ),
    .burst_o,
    .burst_valid_o ( split_valid ),
    .burst_ready_i ( split_ready )
  );

  dma_id_tracker i_id_tracker (
    .clk_i,
    .arst_n_i,
    .issue_i      ( issue        ),
    .burst_last_i ( burst_o.last ),
    .burst_fire_i ( burst_fire   ),
    .flags_full_o ( flags_full   ),
    .rsp_valid_i,
    .rsp_ready_o,
    .next_id_o,
    .done_id_o,
    .busy_o
  );

endmodule

`default_nettype wire

// File: verif/dma_clk_gen.sv
// Testbench clock and reset source for the DMA job path
`default_nettype none

module dma_clk_gen #(
  parameter int unsigned PERIOD       = 100,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/dma_wrap_props.sv
// Port assertions for the DMA job path top: reset state, page limits and burst stability
`default_nettype none

`include "dma_defs.svh"

module dma_wrap_props (
  input logic            clk_i,
  input logic            arst_n_i,
  input logic            job_ready_o,
  input dma_pkg::burst_t burst_o,
  input logic            burst_valid_o,
  input logic            burst_ready_i,
  input logic            rsp_ready_o,
  input dma_pkg::tid_t   next_id_o,
  input dma_pkg::tid_t   done_id_o,
  input logic            busy_o
);

  localparam int unsigned PageSize = 1 << `DMA_PAGE_BITS;

  int unsigned fail_count = 0;

  // Idle outputs during reset and on the first edge after it
  reset_idle: assert property (@(posedge clk_i)
    (!arst_n_i || $rose(arst_n_i)) |->
      !burst_valid_o && !busy_o && job_ready_o && !rsp_ready_o &&
      next_id_o == '0 && done_id_o == '0)
  else begin
    $error("outputs are not idle around reset");
    fail_count++;
  end

  // A burst stays within one page on both sides
  page_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    burst_valid_o |-> burst_o.len != '0 &&
      32'(burst_o.src[`DMA_PAGE_BITS-1:0]) + 32'(burst_o.len) <= PageSize &&
      32'(burst_o.dst[`DMA_PAGE_BITS-1:0]) + 32'(burst_o.len) <= PageSize)
  else begin
    $error("burst is empty or crosses a page boundary");
    fail_count++;
  end

  // Stalled burst holds valid and data
  burst_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    burst_valid_o && !burst_ready_i |=> burst_valid_o && $stable(burst_o))
  else begin
    $error("burst changed or dropped while stalled");
    fail_count++;
  end

endmodule

`default_nettype wire

// File: verif/dma_tb.sv
// Testbench for the DMA job path with random 2D jobs, a backend model and burst checks
`default_nettype none

`include "dma_defs.svh"

module dma_tb;

  import dma_pkg::*;

  localparam int unsigned Period    = 100;
  localparam int unsigned NumJobs   = 40;
  localparam int unsigned PageSize  = 1 << `DMA_PAGE_BITS;
  // Up to 3x3 copies per job and at most 3 pieces per copy
  localparam int unsigned MaxBursts = 27;
  localparam int unsigned Margin    = 20;
  localparam longint unsigned Timeout = longint'(NumJobs) * MaxBursts * Period * Margin;

  logic        clk;
  logic        arst_n;
  job_t        job;
  logic        job_valid;
  logic        job_ready;
  burst_t      burst;
  logic        burst_valid;
  logic        burst_ready;
  logic        rsp_valid;
  logic        rsp_ready;
  tid_t        next_id;
  tid_t        done_id;
  logic        busy;

  int          seed = 32'h5238ec5e;
  burst_t      exp_q[$];
  logic        last_q[$];
  int unsigned jobs_made;
  int unsigned jobs_issued;
  int unsigned jobs_retired;
  logic        job_fired;
  logic        rsp_fired;

  dma_clk_gen #(
    .PERIOD       ( Period ),
    .RESET_CYCLES ( 16     )
  ) i_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  dma_wrap i_dut (
    .clk_i         ( clk         ),
    .arst_n_i      ( arst_n      ),
    .job_i         ( job         ),
    .job_valid_i   ( job_valid   ),
    .job_ready_o   ( job_ready   ),
    .burst_o       ( burst       ),
    .burst_valid_o ( burst_valid ),
    .burst_ready_i ( burst_ready ),
    .rsp_valid_i   ( rsp_valid   ),
    .rsp_ready_o   ( rsp_ready   ),
    .next_id_o     ( next_id     ),
    .done_id_o     ( done_id     ),
    .busy_o        ( busy        )
  );

  bind dma_wrap dma_wrap_props i_props (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .job_ready_o   ( job_ready_o   ),
    .burst_o       ( burst_o       ),
    .burst_valid_o ( burst_valid_o ),
    .burst_ready_i ( burst_ready_i ),
    .rsp_ready_o   ( rsp_ready_o   ),
    .next_id_o     ( next_id_o     ),
    .done_id_o     ( done_id_o     ),
    .busy_o        ( busy_o        )
  );

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // Cut one copy at source and destination page boundaries
  task automatic push_pieces(input addr_t src, input addr_t dst, input len_t len,
                             input logic last);
    int unsigned rem;
    int unsigned src_room;
    int unsigned dst_room;
    int unsigned piece;
    rem = len;
    while (rem > 0) begin
      src_room = PageSize - (src % PageSize);
      dst_room = PageSize - (dst % PageSize);
      piece = rem;
      if (src_room < piece) piece = src_room;
      if (dst_room < piece) piece = dst_room;
      exp_q.push_back('{src: src, dst: dst, len: len_t'(piece), last: last && (piece == rem)});
      src += piece;
      dst += piece;
      rem -= piece;
    end
  endtask

  // Dimension 0 is the outer loop and dimension 1 the inner one
  task automatic expand_job(input job_t j);
    int unsigned n0;
    int unsigned n1;
    int unsigned a;
    int unsigned b;
    n0 = (j.reps[0] == '0) ? 1 : j.reps[0];
    n1 = (j.reps[1] == '0) ? 1 : j.reps[1];
    for (a = 0; a < n0; a++) begin
      for (b = 0; b < n1; b++) begin
        push_pieces(j.src + a * j.src_stride[0] + b * j.src_stride[1],
                    j.dst + a * j.dst_stride[0] + b * j.dst_stride[1],
                    j.len, (a == n0 - 1) && (b == n1 - 1));
      end
    end
  endtask

  // Bases in the last 512 bytes of a page so that bursts often cross
  task automatic make_job(output job_t j);
    logic [31:0] r;
    int          k;
    r = $random(seed);
    j.src = {r[31:12], 12'hfff - {3'b000, r[8:0]}};
    r = $random(seed);
    j.dst = {r[31:12], 12'hfff - {3'b000, r[8:0]}};
    r = $random(seed);
    j.len = len_t'(1 + r % 300);
    for (k = 0; k < `DMA_NUM_REP; k++) begin
      r = $random(seed);
      j.reps[k] = rep_t'(r[1:0]);
      r = $random(seed);
      j.src_stride[k] = addr_t'(r[12:0]);
      r = $random(seed);
      j.dst_stride[k] = addr_t'(r[12:0]);
    end
  endtask

  initial begin : stimulus
    job_t j;
    job         = '0;
    job_valid   = 1'b0;
    burst_ready = 1'b0;
    rsp_valid   = 1'b0;
    jobs_made   = 0;
    wait (arst_n);
    @(negedge clk);
    while (jobs_made < NumJobs || job_valid || exp_q.size() != 0 || last_q.size() != 0) begin
      if (job_valid && job_fired) job_valid = 1'b0;
      if (!job_valid && jobs_made < NumJobs && ($random(seed) & 1)) begin
        make_job(j);
        expand_job(j);
        job       = j;
        job_valid = 1'b1;
        jobs_made++;
      end
      burst_ready = ($random(seed) & 3) != 0;
      // A pending response holds until it is taken
      if (!rsp_valid || rsp_fired) rsp_valid = ($random(seed) & 1) != 0;
      @(negedge clk);
    end
    rsp_valid   = 1'b0;
    burst_ready = 1'b0;
    repeat (2) @(negedge clk);
    assert (next_id == tid_t'(NumJobs))
      else stop_with_failure($sformatf("error: next_id_o is %h, expected %h",
                                       next_id, tid_t'(NumJobs)));
    assert (done_id == tid_t'(NumJobs))
      else stop_with_failure($sformatf("error: done_id_o is %h, expected %h",
                                       done_id, tid_t'(NumJobs)));
    assert (!busy)
      else stop_with_failure($sformatf("error: busy_o is %h, expected 0", busy));
    if (i_dut.i_props.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_failure("a port assertion on the DUT failed");
    end
  end

  // Backend model and checker that sample pre-edge values
  always @(posedge clk) begin : monitor
    burst_t want;
    if (!arst_n) begin
      job_fired    = 1'b0;
      rsp_fired    = 1'b0;
      jobs_issued  = 0;
      jobs_retired = 0;
    end else begin
      if (i_dut.i_props.fail_count != 0) stop_with_failure("a port assertion on the DUT failed");
      assert (next_id == tid_t'(jobs_issued))
        else stop_with_failure($sformatf("error: next_id_o is %h, expected %h",
                                         next_id, tid_t'(jobs_issued)));
      assert (done_id == tid_t'(jobs_retired))
        else stop_with_failure($sformatf("error: done_id_o is %h, expected %h",
                                         done_id, tid_t'(jobs_retired)));
      assert (busy == (jobs_issued != jobs_retired))
        else stop_with_failure($sformatf("error: busy_o is %h, expected %h",
                                         busy, jobs_issued != jobs_retired));
      job_fired = job_valid && job_ready;
      rsp_fired = rsp_valid && rsp_ready;
      if (job_fired) jobs_issued++;
      if (rsp_fired) begin
        if (last_q.size() == 0) begin
          stop_with_failure("a response was taken with no burst outstanding");
        end else if (last_q.pop_front()) begin
          jobs_retired++;
        end
      end
      if (burst_valid && burst_ready) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("a burst was sent when none was expected");
        end else begin
          want = exp_q.pop_front();
          assert (burst == want)
            else stop_with_failure($sformatf("error: burst_o is %h, expected %h", burst, want));
          last_q.push_back(want.last);
        end
      end
    end
  end

  initial begin : watchdog
    #(Timeout);
    stop_with_failure("timeout: the jobs did not complete in time");
  end

endmodule

`default_nettype wire

// File: dma_wrap.f
+incdir+include
logic/dma_pkg.sv
logic/dma_job_queue.sv
logic/dma_rep_stage.sv
logic/dma_page_splitter.sv
logic/dma_id_tracker.sv
logic/dma_wrap.sv
verif/dma_clk_gen.sv
verif/dma_wrap_props.sv
verif/dma_tb.sv

// File: Bender.yml
package:
  name: dma_wrap

export_include_dirs:
  - include

sources:
  # RTL
  - files:
      - logic/dma_pkg.sv
      - logic/dma_job_queue.sv
      - logic/dma_rep_stage.sv
      - logic/dma_page_splitter.sv
      - logic/dma_id_tracker.sv
      - logic/dma_wrap.sv
  # Verification
  - target: test
    files:
      - verif/dma_clk_gen.sv
      - verif/dma_wrap_props.sv
      - verif/dma_tb.sv
